// File: verilog/memCtrl_macros.svh
`ifndef MEMCTRL_MACROS_SVH
`define MEMCTRL_MACROS_SVH

// processor address width
`define ADDR_W 32

// processor word width
`define WORD_W 32

// ram moves one of these per cycle
`define BYTE_W 8

// bytes held by the ram
`define RAM_DEPTH 4096

`endif

// File: verilog/memCtrlPkg.sv
`include "memCtrl_macros.svh"

package memCtrlPkg;

    typedef logic [`ADDR_W-1:0] addr_t;
    typedef logic [`WORD_W-1:0] word_t;
    typedef logic [`BYTE_W-1:0] byte_t;

    // value is the byte count of the access
    typedef enum logic [2:0] {
        LenByte = 3'd1,
        LenHalf = 3'd2,
        LenWord = 3'd4
    } accessLen_t;

    // kind of request being served
    typedef enum logic [1:0] {
        OpFetch,
        OpLoad,
        OpStore
    } reqKind_t;

endpackage

// File: verilog/memArbiter.sv
`timescale 1ns/1ps

module memArbiter (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   i_rdy,
    input  logic                   i_ioBufferFull,
    input  logic                   i_fetchEn,
    input  logic                   i_dataEn,
    input  logic                   i_dataStore,
    input  memCtrlPkg::accessLen_t i_dataLen,
    input  logic                   i_lastByte,
    output logic                   o_advance,
    output logic                   o_start,
    output memCtrlPkg::accessLen_t o_startLen,
    output memCtrlPkg::reqKind_t   o_op,
    output logic                   o_memWrite,
    output logic                   o_readIssue,
    output logic                   o_fetchDone,
    output logic                   o_dataDone
);
    import memCtrlPkg::*;

    typedef enum logic [1:0] {
        Idle,
        Access,
        Finish
    } state_t;

    state_t   state;
    reqKind_t curOp;
    reqKind_t newOp;
    logic     anyDone;
    logic     anyReq;

    // the only stall source seen by the rest of the controller
    assign o_advance = i_rdy && !i_ioBufferFull;

    // a strobe in flight means the requester still holds its enable
    assign anyDone = o_fetchDone || o_dataDone;
    assign anyReq = i_fetchEn || i_dataEn;

    // data side wins over fetch
    always_comb begin
        if (i_dataEn) begin
            newOp = i_dataStore ? OpStore : OpLoad;
        end else begin
            newOp = OpFetch;
        end
    end

    assign o_start = (state == Idle) && o_advance && anyReq && !anyDone;
    assign o_startLen = i_dataEn ? i_dataLen : LenWord;
    assign o_op = (state == Idle) ? newOp : curOp;

    assign o_memWrite = (state == Access) && (curOp == OpStore) && o_advance;
    assign o_readIssue = (state == Access) && (curOp != OpStore);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= Idle;
            curOp <= OpFetch;
            o_fetchDone <= 1'b0;
            o_dataDone <= 1'b0;
        end else begin
            // strobes last one cycle, even across a stall
            o_fetchDone <= 1'b0;
            o_dataDone <= 1'b0;
            case (state)
                Idle: begin
                    if (o_start) begin
                        state <= Access;
                        curOp <= newOp;
                    end
                end
                Access: begin
                    if (o_advance && i_lastByte) begin
                        state <= Finish;
                    end
                end
                Finish: begin
                    if (o_advance) begin
                        state <= Idle;
                        o_fetchDone <= (curOp == OpFetch);
                        o_dataDone <= (curOp != OpFetch);
                    end
                end
                default: begin
                    state <= Idle;
                end
            endcase
        end
    end

endmodule

// File: verilog/byteCounter.sv
`timescale 1ns/1ps

module byteCounter (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   i_advance,
    input  logic                   i_start,
    input  memCtrlPkg::accessLen_t i_startLen,
    output logic [1:0]             o_index,
    output logic                   o_lastByte
);
    import memCtrlPkg::*;

    accessLen_t len;

    assign o_lastByte = ({1'b0, o_index} == (len - 3'd1));

    always_ff @(posedge clk) begin
        if (rst) begin
            len <= LenWord;
            o_index <= 2'd0;
        end else if (i_start) begin
            len <= i_startLen;
            o_index <= 2'd0;
        end else if (i_advance && !o_lastByte) begin
            // parks on the last byte until the next start
            o_index <= o_index + 2'd1;
        end
    end

endmodule

// File: verilog/memPortDriver.sv
`timescale 1ns/1ps

module memPortDriver (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 i_advance,
    input  logic                 i_start,
    input  memCtrlPkg::reqKind_t i_op,
    input  memCtrlPkg::addr_t    i_fetchAddr,
    input  memCtrlPkg::addr_t    i_dataAddr,
    input  memCtrlPkg::word_t    i_dataWrData,
    input  logic [1:0]           i_index,
    input  logic                 i_lastByte,
    output memCtrlPkg::addr_t    o_memAddr,
    output memCtrlPkg::byte_t    o_memData
);
    import memCtrlPkg::*;

    addr_t base;
    word_t storeWord;
    logic  active;

    // address only leaves zero during the address cycles
    assign o_memAddr = active ? (base + addr_t'(i_index)) : '0;
    assign o_memData = storeWord[i_index * $bits(byte_t) +: $bits(byte_t)];

    always_ff @(posedge clk) begin
        if (rst) begin
            active <= 1'b0;
        end else if (i_start) begin
            active <= 1'b1;
        end else if (i_advance && i_lastByte) begin
            active <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (i_start) begin
            base <= (i_op == OpFetch) ? i_fetchAddr : i_dataAddr;
            storeWord <= i_dataWrData;
        end
    end

endmodule

// File: verilog/readAssembler.sv
`timescale 1ns/1ps

module readAssembler (
    input  logic              clk,
    input  logic              rst,
    input  logic              i_advance,
    input  logic              i_start,
    input  logic              i_readIssue,
    input  logic [1:0]        i_index,
    input  memCtrlPkg::byte_t i_memData,
    output memCtrlPkg::word_t o_word
);
    import memCtrlPkg::*;

    logic       pendValid;
    logic [1:0] pendLane;

    always_ff @(posedge clk) begin
        if (rst) begin
            o_word <= '0;
            pendValid <= 1'b0;
            pendLane <= 2'd0;
        end else if (i_start) begin
            // zeroed word gives zero extension for short loads
            o_word <= '0;
            pendValid <= 1'b0;
        end else begin
            // only an address that really went out becomes pending
            pendValid <= i_readIssue && i_advance;
            pendLane <= i_index;
            // ram data trails its address by one edge whatever the stall
            if (pendValid) begin
                o_word[pendLane * $bits(byte_t) +: $bits(byte_t)] <= i_memData;
            end
        end
    end

endmodule

// File: verilog/memCtrl.sv
`timescale 1ns/1ps

module memCtrl (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   i_rdy,
    input  logic                   i_ioBufferFull,
    input  memCtrlPkg::byte_t      i_memData,
    output logic                   o_memWrite,
    output memCtrlPkg::addr_t      o_memAddr,
    output memCtrlPkg::byte_t      o_memData,
    input  logic                   i_fetchEn,
    input  memCtrlPkg::addr_t      i_fetchAddr,
    output logic                   o_fetchDone,
    output memCtrlPkg::word_t      o_fetchInst,
    input  logic                   i_dataEn,
    input  logic                   i_dataStore,
    input  memCtrlPkg::accessLen_t i_dataLen,
    input  memCtrlPkg::addr_t      i_dataAddr,
    input  memCtrlPkg::word_t      i_dataWrData,
    output logic                   o_dataDone,
    output memCtrlPkg::word_t      o_dataRdData
);
    import memCtrlPkg::*;

    logic       advance;
    logic       start;
    accessLen_t startLen;
    reqKind_t   op;
    logic       readIssue;
    logic [1:0] index;
    logic       lastByte;
    word_t      word;

    memArbiter i_memArbiter (
        .clk           (clk),
        .rst           (rst),
        .i_rdy         (i_rdy),
        .i_ioBufferFull(i_ioBufferFull),
        .i_fetchEn     (i_fetchEn),
        .i_dataEn      (i_dataEn),
        .i_dataStore   (i_dataStore),
        .i_dataLen     (i_dataLen),
        .i_lastByte    (lastByte),
        .o_advance     (advance),
        .o_start       (start),
        .o_startLen    (startLen),
        .o_op          (op),
        .o_memWrite    (o_memWrite),
        .o_readIssue   (readIssue),
        .o_fetchDone   (o_fetchDone),
        .o_dataDone    (o_dataDone)
    );

    byteCounter i_byteCounter (
        .clk       (clk),
        .rst       (rst),
        .i_advance (advance),
        .i_start   (start),
        .i_startLen(startLen),
        .o_index   (index),
        .o_lastByte(lastByte)
    );

    memPortDriver i_memPortDriver (
        .clk         (clk),
        .rst         (rst),
        .i_advance   (advance),
        .i_start     (start),
        .i_op        (op),
        .i_fetchAddr (i_fetchAddr),
        .i_dataAddr  (i_dataAddr),
        .i_dataWrData(i_dataWrData),
        .i_index     (index),
        .i_lastByte  (lastByte),
        .o_memAddr   (o_memAddr),
        .o_memData   (o_memData)
    );

    readAssembler i_readAssembler (
        .clk        (clk),
        .rst        (rst),
        .i_advance  (advance),
        .i_start    (start),
        .i_readIssue(readIssue),
        .i_index    (index),
        .i_memData  (i_memData),
        .o_word     (word)
    );

    // one assembler word, valid for whichever side sees its done strobe
    assign o_fetchInst = word;
    assign o_dataRdData = word;

endmodule

// File: testbench/tbRamModel.sv
`timescale 1ns/1ps
`include "memCtrl_macros.svh"

module tbRamModel (
    input  logic               clk,
    input  logic               rst,
    input  logic               i_we,
    input  logic [`ADDR_W-1:0] i_addr,
    input  logic [`BYTE_W-1:0] i_wrData,
    input  logic               i_stalled,
    output logic [`BYTE_W-1:0] o_rdData,
    output int                 o_badWrites
);

    logic [`BYTE_W-1:0] mem [0:`RAM_DEPTH-1];
    int                 idx;

    assign idx = int'(i_addr % `RAM_DEPTH);

    // one cycle read latency, reads every cycle
    always @(posedge clk) begin
        o_rdData <= mem[idx];
        if (rst) begin
            o_badWrites <= 0;
        end else if (i_we) begin
            if (i_stalled) begin
                $display("RAM model: write in a stalled cycle at address %h", i_addr);
                o_badWrites <= o_badWrites + 1;
            end
            mem[idx] <= i_wrData;
        end
    end

endmodule

// File: testbench/memCtrlTb.sv
`timescale 1ns/1ps
`include "memCtrl_macros.svh"

module memCtrlTb;
    import memCtrlPkg::*;

    localparam int Timeout = 300;

    logic clk = 1'b0;
    logic rst, rdy, ioFull, fetchEn, dataEn, dataStore, memWrite, fetchDone, dataDone;
    accessLen_t dataLen;
    addr_t fetchAddr, dataAddr, memAddr;
    word_t dataWrData, fetchInst, dataRdData;
    byte_t ramRdData, memWrData;
    int badWrites;

    byte_t shadow [0:`RAM_DEPTH-1];
    logic [31:0] rngMain;
    logic [31:0] rngStall;
    logic stallOn;
    int errors;
    int testErrors;
    int tests;
    // store being checked by the write monitor
    addr_t stBase;
    int stLen;
    word_t stData;
    int stCount;

    always #5 clk = ~clk;

    memCtrl i_memCtrl (
        .clk(clk), .rst(rst), .i_rdy(rdy), .i_ioBufferFull(ioFull),
        .i_memData(ramRdData), .o_memWrite(memWrite), .o_memAddr(memAddr),
        .o_memData(memWrData), .i_fetchEn(fetchEn), .i_fetchAddr(fetchAddr),
        .o_fetchDone(fetchDone), .o_fetchInst(fetchInst), .i_dataEn(dataEn),
        .i_dataStore(dataStore), .i_dataLen(dataLen), .i_dataAddr(dataAddr),
        .i_dataWrData(dataWrData), .o_dataDone(dataDone), .o_dataRdData(dataRdData)
    );

    tbRamModel i_ram (
        .clk(clk), .rst(rst), .i_we(memWrite), .i_addr(memAddr), .i_wrData(memWrData),
        .i_stalled(!rdy || ioFull), .o_rdData(ramRdData), .o_badWrites(badWrites)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // zero-extended little-endian read of the shadow
    function automatic word_t expectedRead(input addr_t addr, input int len);
        word_t w;
        w = '0;
        for (int i = 0; i < len; i++) begin
            w[i*8 +: 8] = shadow[(addr + i) % `RAM_DEPTH];
        end
        return w;
    endfunction

    task automatic compareWord(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("** Error: %s = 0x%h, expected 0x%h", name, got, exp);
            errors++;
        end
    endtask

    task automatic compareByte(input string name, input byte_t got, input byte_t exp);
        if (got !== exp) begin
            $display("** Error: %s = 0x%h, expected 0x%h", name, got, exp);
            errors++;
        end
    endtask

    task automatic finishTest(input string name);
        tests++;
        if (errors == testErrors) begin
            $display("test %0s: ok", name);
        end else begin
            $display("test %0s: %0d errors", name, errors - testErrors);
        end
        testErrors = errors;
    endtask

    task automatic reportTimeout(input string what);
        $display("timeout: no %0s done strobe", what);
        errors++;
    endtask

    function automatic accessLen_t pickLen(input logic [31:0] r);
        case (r % 3)
            0: return LenByte;
            1: return LenHalf;
            default: return LenWord;
        endcase
    endfunction

    // stall pattern from its own generator
    always @(negedge clk) begin
        if (stallOn) begin
            rngStall = xorshift(rngStall);
            rdy = rngStall[0] | rngStall[1];
            ioFull = rngStall[2] & rngStall[3] & rngStall[4];
        end else begin
            rdy = 1'b1;
            ioFull = 1'b0;
        end
    end

    // every written byte must belong to the store in flight
    always @(posedge clk) begin
        if (!rst && memWrite) begin
            if (memAddr - stBase >= addr_t'(stLen)) begin
                $display("write to address %h outside the current store", memAddr);
                errors++;
            end else begin
                compareByte("o_memData", memWrData, stData[(memAddr - stBase) * 8 +: 8]);
            end
            stCount++;
        end
    end

    task automatic issueFetch(input addr_t addr, input logic checkLatency);
        int cycles;
        @(negedge clk);
        fetchEn = 1'b1;
        fetchAddr = addr;
        cycles = 0;
        while (!fetchDone && cycles < Timeout) begin
            @(posedge clk);
            cycles++;
        end
        if (!fetchDone) begin
            reportTimeout("fetch");
        end else begin
            compareWord("o_fetchInst", fetchInst, expectedRead(addr, 4));
            // the seventh edge counted here ends the strobe cycle
            if (checkLatency && cycles != 7) begin
                $display("fetch done strobe after %0d edges instead of 7", cycles);
                errors++;
            end
        end
        @(negedge clk);
        fetchEn = 1'b0;
        @(posedge clk);
        if (fetchDone) begin
            $display("fetch done strobe held for more than one cycle");
            errors++;
        end
    endtask

    task automatic accessData(input logic store, input accessLen_t len, input addr_t addr,
                              input word_t data);
        int cycles;
        @(negedge clk);
        stBase = addr;
        stLen = store ? int'(len) : 0;
        stData = data;
        stCount = 0;
        dataEn = 1'b1;
        dataStore = store;
        dataLen = len;
        dataAddr = addr;
        dataWrData = data;
        cycles = 0;
        while (!dataDone && cycles < Timeout) begin
            @(posedge clk);
            cycles++;
        end
        if (!dataDone) begin
            reportTimeout("data");
        end else if (store) begin
            for (int i = 0; i < int'(len); i++) begin
                shadow[(addr + i) % `RAM_DEPTH] = data[i*8 +: 8];
            end
            if (stCount != int'(len)) begin
                $display("store of %0d bytes wrote %0d bytes", int'(len), stCount);
                errors++;
            end
        end else begin
            compareWord("o_dataRdData", dataRdData, expectedRead(addr, int'(len)));
        end
        @(negedge clk);
        dataEn = 1'b0;
    endtask

    task automatic raceFetchAndData(input addr_t fAddr, input addr_t dAddr,
                                    input accessLen_t len);
        int cycles;
        int fCycle;
        int dCycle;
        @(negedge clk);
        fetchEn = 1'b1;
        fetchAddr = fAddr;
        dataEn = 1'b1;
        dataStore = 1'b0;
        dataLen = len;
        dataAddr = dAddr;
        stLen = 0;
        cycles = 0;
        fCycle = 0;
        dCycle = 0;
        while ((fCycle == 0 || dCycle == 0) && cycles < Timeout) begin
            @(posedge clk);
            cycles++;
            if (dataDone && dCycle == 0) begin
                dCycle = cycles;
                compareWord("o_dataRdData", dataRdData, expectedRead(dAddr, int'(len)));
                @(negedge clk);
                dataEn = 1'b0;
            end else if (fetchDone && fCycle == 0) begin
                fCycle = cycles;
                compareWord("o_fetchInst", fetchInst, expectedRead(fAddr, 4));
                @(negedge clk);
                fetchEn = 1'b0;
            end
        end
        if (fCycle == 0 || dCycle == 0) begin
            reportTimeout("fetch or data");
            @(negedge clk);
            fetchEn = 1'b0;
            dataEn = 1'b0;
        end else if (fCycle < dCycle) begin
            $display("fetch finished before the data request that came with it");
            errors++;
        end
    endtask

    initial begin
        addr_t a;
        accessLen_t len;
        rst = 1'b1;
        rdy = 1'b1;
        ioFull = 1'b0;
        fetchEn = 1'b0;
        dataEn = 1'b0;
        dataStore = 1'b0;
        dataLen = LenWord;
        fetchAddr = '0;
        dataAddr = '0;
        dataWrData = '0;
        stallOn = 1'b0;
        errors = 0;
        testErrors = 0;
        tests = 0;
        stBase = '0;
        stLen = 0;
        stData = '0;
        stCount = 0;
        rngMain = 32'hc552;
        rngStall = xorshift(32'hc552 ^ 32'h5a5a0f0f);
        for (int i = 0; i < `RAM_DEPTH; i++) begin
            shadow[i] = byte_t'((i * 37) ^ (i >> 4) ^ (i >> 9));
            i_ram.mem[i] = shadow[i];
        end

        repeat (16) begin
            @(posedge clk);
            if (memWrite || fetchDone || dataDone) begin
                $display("write enable or done strobe high during reset");
                errors++;
            end
        end
        @(negedge clk);
        rst = 1'b0;
        @(posedge clk);
        if (memWrite || fetchDone || dataDone) begin
            $display("write enable or done strobe high after reset");
            errors++;
        end
        finishTest("reset");

        for (int i = 0; i < 8; i++) begin
            rngMain = xorshift(rngMain);
            issueFetch(addr_t'(rngMain % (`RAM_DEPTH - 4)), i == 0);
        end
        finishTest("fetch");

        for (int i = 0; i < 12; i++) begin
            rngMain = xorshift(rngMain);
            a = addr_t'(rngMain % (`RAM_DEPTH - 4));
            len = (i % 3 == 0) ? LenByte : ((i % 3 == 1) ? LenHalf : LenWord);
            accessData(1'b0, len, a, '0);
        end
        finishTest("loads");

        for (int i = 0; i < 9; i++) begin
            rngMain = xorshift(rngMain);
            a = addr_t'(rngMain % (`RAM_DEPTH - 4));
            len = (i % 3 == 0) ? LenByte : ((i % 3 == 1) ? LenHalf : LenWord);
            rngMain = xorshift(rngMain);
            accessData(1'b1, len, a, rngMain);
            accessData(1'b0, LenWord, a, '0);
        end
        finishTest("stores");

        for (int i = 0; i < 3; i++) begin
            rngMain = xorshift(rngMain);
            a = addr_t'(rngMain % (`RAM_DEPTH - 4));
            rngMain = xorshift(rngMain);
            raceFetchAndData(a, addr_t'(rngMain % (`RAM_DEPTH - 4)), pickLen(rngMain >> 12));
        end
        finishTest("priority");

        stallOn = 1'b1;
        for (int i = 0; i < 30; i++) begin
            rngMain = xorshift(rngMain);
            a = addr_t'(rngMain % (`RAM_DEPTH - 4));
            len = pickLen(rngMain >> 16);
            if (rngMain[31:30] == 2'd0) begin
                issueFetch(a, 1'b0);
            end else begin
                rngMain = xorshift(rngMain);
                accessData(rngMain[7], len, a, rngMain);
            end
        end
        stallOn = 1'b0;
        if (badWrites != 0) begin
            $display("RAM model saw %0d writes in stalled cycles", badWrites);
            errors++;
        end
        finishTest("stalls");

        $display("%0d tests, %0d errors", tests, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// File: verilog.f
+incdir+verilog
verilog/memCtrlPkg.sv
verilog/memArbiter.sv
verilog/byteCounter.sv
verilog/memPortDriver.sv
verilog/readAssembler.sv
verilog/memCtrl.sv
testbench/tbRamModel.sv
testbench/memCtrlTb.sv

// File: Makefile
TOP := memCtrlTb

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, check for the pass message"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing -Wno-fatal -f verilog.f --top-module $(TOP) -o $(TOP)
	@out=$$(./obj_dir/$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "Done: no errors"

clean:
	rm -rf obj_dir
